// ==== Makefile ====
# Verilator build and run for the FP cluster testbench.
# The run target fails when the simulation exits with a nonzero status.

VERILATOR  ?= verilator
TOP        ?= fpu_cluster_tb
FILELIST   ?= fpu_cluster.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SRCS    := $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)

// ==== include/fpu_ref_model.svh ====
// Reference model of the cluster operations for the testbench scoreboard.
// Include inside the testbench module; call ref_model once per accepted request
// to get the expected result word and status flags.

`ifndef FPU_REF_MODEL_SVH
`define FPU_REF_MODEL_SVH

// Unsigned key that sorts like the float value, -0 just below +0
function automatic logic [31:0] ref_order_key(logic [31:0] w);
  return w[31] ? ~w : (w | 32'h8000_0000);
endfunction

function automatic logic [9:0] ref_classify(logic [31:0] w);
  logic [9:0] cls;
  cls = '0;
  if (w[30:23] == 8'hff && w[22:0] != 0) begin
    cls[w[22] ? fp_format_pkg::CLASS_QNAN : fp_format_pkg::CLASS_SNAN] = 1'b1;
  end else if (w[30:23] == 8'hff) begin
    cls[w[31] ? fp_format_pkg::CLASS_NEG_INF : fp_format_pkg::CLASS_POS_INF] = 1'b1;
  end else if (w[30:0] == 0) begin
    cls[w[31] ? fp_format_pkg::CLASS_NEG_ZERO : fp_format_pkg::CLASS_POS_ZERO] = 1'b1;
  end else if (w[30:23] == 0) begin
    cls[w[31] ? fp_format_pkg::CLASS_NEG_SUBNORM : fp_format_pkg::CLASS_POS_SUBNORM] = 1'b1;
  end else begin
    cls[w[31] ? fp_format_pkg::CLASS_NEG_NORM : fp_format_pkg::CLASS_POS_NORM] = 1'b1;
  end
  return cls;
endfunction

function automatic void ref_model(
  input  fpu_op_pkg::fpu_op_e   op,
  input  logic                  op_mod,
  input  fpu_op_pkg::rnd_mode_e rnd,
  input  logic [31:0]           a,
  input  logic [31:0]           b,
  output logic [31:0]           result,
  output logic [4:0]            status
);
  logic [9:0] ca, cb;
  logic       a_nan, b_nan, snan, lt, eq, cmp;
  ca     = ref_classify(a);
  cb     = ref_classify(b);
  a_nan  = ca[fp_format_pkg::CLASS_SNAN] | ca[fp_format_pkg::CLASS_QNAN];
  b_nan  = cb[fp_format_pkg::CLASS_SNAN] | cb[fp_format_pkg::CLASS_QNAN];
  snan   = ca[fp_format_pkg::CLASS_SNAN] | cb[fp_format_pkg::CLASS_SNAN];
  eq     = (a == b) || ((a[30:0] == 0) && (b[30:0] == 0));
  lt     = (ref_order_key(a) < ref_order_key(b)) && !eq;
  result = a;
  status = '0;
  case (op)
    fpu_op_pkg::OP_MINMAX: begin
      status[fpu_op_pkg::FLAG_NV] = snan;
      if (a_nan && b_nan) result = fp_format_pkg::CANON_NAN;
      else if (a_nan)     result = b;
      else if (b_nan)     result = a;
      else if (rnd == fpu_op_pkg::RTZ) result = (ref_order_key(a) < ref_order_key(b)) ? b : a;
      else                result = (ref_order_key(a) < ref_order_key(b)) ? a : b;
    end
    fpu_op_pkg::OP_SGNJ: begin
      if (rnd == fpu_op_pkg::RTZ)      result[31] = ~b[31];
      else if (rnd == fpu_op_pkg::RDN) result[31] = a[31] ^ b[31];
      else                             result[31] = b[31];
    end
    fpu_op_pkg::OP_CMP: begin
      if (rnd == fpu_op_pkg::RNE)      cmp = lt || eq;
      else if (rnd == fpu_op_pkg::RTZ) cmp = lt;
      else if (rnd == fpu_op_pkg::RDN) cmp = eq;
      else                             cmp = 1'b0;
      if (a_nan || b_nan) cmp = 1'b0;
      status[fpu_op_pkg::FLAG_NV] = snan ||
          ((a_nan || b_nan) && (rnd == fpu_op_pkg::RNE || rnd == fpu_op_pkg::RTZ));
      result = {31'b0, cmp ^ op_mod};
    end
    default: result = {22'b0, ca};
  endcase
endfunction

`endif

// ==== dv/fpu_cluster_tb.sv ====
// Randomized testbench for the FP cluster.
// Drives requests and output back-pressure from a fixed seed, checks each
// result against the reference model in acceptance order, guarded by a watchdog.

module fpu_cluster_tb;
  import fpu_op_pkg::*;
  import fp_format_pkg::*;

  localparam int NUM_LANES      = 4;
  localparam int TAG_WIDTH      = 8;
  localparam int CLK_PERIOD     = 10;
  localparam int NUM_REQS       = 2000;
  localparam int DRAIN_LIMIT    = 200;
  localparam int TIMEOUT_CYCLES = NUM_REQS * 20 + 500;

  `include "fpu_ref_model.svh"

  logic                 clk, rst_n;
  fp_word_u             operand_a, operand_b;
  fpu_op_e              op;
  logic                 op_mod;
  rnd_mode_e            rnd_mode;
  logic [TAG_WIDTH-1:0] tag;
  logic                 in_valid, in_ready, out_valid, out_ready;
  logic [FLEN-1:0]      result;
  logic [STATUS_W-1:0]  status;
  logic [TAG_WIDTH-1:0] tag_out;

  // Expected responses, oldest accepted request first
  logic [FLEN-1:0]      exp_result_q[$];
  logic [STATUS_W-1:0]  exp_status_q[$];
  logic [TAG_WIDTH-1:0] exp_tag_q[$];

  int   n_sent, n_checked, drain_cycles;
  logic in_fire, out_fire, held;
  logic [FLEN+STATUS_W+TAG_WIDTH-1:0] held_word;

  tb_clk_gen #(
    .PERIOD     (CLK_PERIOD),
    .RST_CYCLES (3)
  ) u_clk_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  fpu_cluster #(
    .NUM_LANES (NUM_LANES),
    .TAG_WIDTH (TAG_WIDTH)
  ) i_dut (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .operand_a_i (operand_a),
    .operand_b_i (operand_b),
    .op_i        (op),
    .op_mod_i    (op_mod),
    .rnd_mode_i  (rnd_mode),
    .tag_i       (tag),
    .in_valid_i  (in_valid),
    .in_ready_o  (in_ready),
    .result_o    (result),
    .status_o    (status),
    .tag_o       (tag_out),
    .out_valid_o (out_valid),
    .out_ready_i (out_ready)
  );

  task automatic fail_and_stop(input string msg);
    $display("%s", msg);
    $display("=== FAIL ===");
    $fatal(1, "Run stopped at time %0t", $time);
  endtask

  // Special values mixed with random words
  function automatic logic [31:0] pick_operand();
    logic sign;
    sign = 1'($urandom_range(0, 1));
    case ($urandom_range(0, 9))
      0: return {sign, 31'h0};
      1: return {sign, 8'hff, 23'h0};
      2: return {sign, 8'hff, 1'b0, 22'($urandom_range(1, 32'h3f_ffff))};
      3: return {sign, 8'hff, 1'b1, 22'($urandom)};
      4: return {sign, 8'h00, 23'($urandom)};
      default: return $urandom;
    endcase
  endfunction

  task automatic new_request();
    operand_a.raw = pick_operand();
    operand_b.raw = ($urandom_range(0, 7) == 0) ? operand_a.raw : pick_operand();
    op            = fpu_op_e'($urandom_range(0, 3));
    op_mod        = 1'($urandom_range(0, 1));
    case ($urandom_range(0, 2))
      0: rnd_mode = RNE;
      1: rnd_mode = RTZ;
      default: rnd_mode = RDN;
    endcase
    tag = TAG_WIDTH'(n_sent);
  endtask

  task automatic push_expected();
    logic [FLEN-1:0]     exp_res;
    logic [STATUS_W-1:0] exp_st;
    ref_model(op, op_mod, rnd_mode, operand_a.raw, operand_b.raw, exp_res, exp_st);
    exp_result_q.push_back(exp_res);
    exp_status_q.push_back(exp_st);
    exp_tag_q.push_back(tag);
    n_sent++;
  endtask

  task automatic check_output();
    logic [FLEN-1:0]      exp_res;
    logic [STATUS_W-1:0]  exp_st;
    logic [TAG_WIDTH-1:0] exp_tag;
    assert (exp_result_q.size() > 0)
      else fail_and_stop("Output transfer while no request was pending");
    exp_res = exp_result_q.pop_front();
    exp_st  = exp_status_q.pop_front();
    exp_tag = exp_tag_q.pop_front();
    assert (tag_out === exp_tag) else fail_and_stop($sformatf(
      "Mismatch tag_o: expected 0x%h, got 0x%h", exp_tag, tag_out));
    assert (result === exp_res) else fail_and_stop($sformatf(
      "Mismatch result_o: expected 0x%h, got 0x%h (tag 0x%h)", exp_res, result, exp_tag));
    assert (status === exp_st) else fail_and_stop($sformatf(
      "Mismatch status_o: expected 0x%h, got 0x%h (tag 0x%h)", exp_st, status, exp_tag));
    n_checked++;
  endtask

  // A stalled output must not change until it is taken
  task automatic check_hold();
    if (held) begin
      assert (out_valid) else fail_and_stop("out_valid_o dropped while out_ready_i was low");
      assert ({result, status, tag_out} === held_word) else fail_and_stop($sformatf(
        "Mismatch held {result_o,status_o,tag_o}: expected 0x%h, got 0x%h",
        held_word, {result, status, tag_out}));
    end
    held      = out_valid && !out_ready;
    held_word = {result, status, tag_out};
  endtask

  // Random traffic for one clock cycle
  task automatic run_cycle();
    @(negedge clk);
    // Fields stay put until the pending request is taken
    if (!in_valid || in_fire) begin
      in_valid = 1'b0;
      if (n_sent < NUM_REQS && $urandom_range(0, 3) != 0) begin
        new_request();
        in_valid = 1'b1;
      end
    end
    out_ready = ($urandom_range(0, 9) < 7);
    @(posedge clk);
    in_fire  = in_valid && in_ready;
    out_fire = out_valid && out_ready;
    check_hold();
    if (out_fire) check_output();
    if (in_fire) push_expected();
  endtask

  initial begin
    void'($urandom(61523));
    operand_a    = '0;
    operand_b    = '0;
    op           = OP_MINMAX;
    op_mod       = 1'b0;
    rnd_mode     = RNE;
    tag          = '0;
    in_valid     = 1'b0;
    out_ready    = 1'b0;
    n_sent       = 0;
    n_checked    = 0;
    drain_cycles = 0;
    in_fire      = 1'b0;
    out_fire     = 1'b0;
    held         = 1'b0;
    held_word    = '0;
    @(posedge rst_n);

    // First request with the output open, result due two edges after accept
    assert (!out_valid) else fail_and_stop("out_valid_o high after reset");
    new_request();
    in_valid  = 1'b1;
    out_ready = 1'b1;
    @(posedge clk);
    assert (in_ready) else fail_and_stop("in_ready_o low for the first request after reset");
    push_expected();
    @(negedge clk);
    in_valid = 1'b0;
    @(posedge clk);
    assert (!out_valid) else fail_and_stop("out_valid_o rose one cycle after accept");
    @(posedge clk);
    assert (out_valid) else fail_and_stop("out_valid_o not high two cycles after accept");
    check_output();

    while (n_sent < NUM_REQS) begin
      run_cycle();
    end

    // Last results drain under the same random back-pressure
    while (exp_result_q.size() > 0 && drain_cycles < DRAIN_LIMIT) begin
      run_cycle();
      drain_cycles++;
    end
    assert (exp_result_q.size() == 0) else fail_and_stop($sformatf(
      "%0d expected results never came out", exp_result_q.size()));

    @(negedge clk);
    in_valid  = 1'b0;
    out_ready = 1'b1;
    repeat (4) begin
      @(posedge clk);
      assert (!out_valid) else fail_and_stop("Extra result after all requests were checked");
    end
    $display("=== PASS ===");
    $finish;
  end

  initial begin
    #(TIMEOUT_CYCLES * CLK_PERIOD);
    fail_and_stop($sformatf("Timeout after %0d cycles with %0d of %0d results checked",
                            TIMEOUT_CYCLES, n_checked, NUM_REQS));
  end

endmodule

// ==== dv/tb_clk_gen.sv ====
// Clock and reset source for the cluster testbench.
// Reset is held low for RST_CYCLES rising edges and released on a falling edge.

module tb_clk_gen #(
  parameter int PERIOD     = 10,
  parameter int RST_CYCLES = 3
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD / 2) clk_o = ~clk_o;
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

// ==== fpu_cluster.f ====
+incdir+include
logic/fpu_op_pkg.sv
logic/fp_format_pkg.sv
logic/fpu_dispatch.sv
logic/fpu_noncomp_lane.sv
logic/fpu_collect.sv
logic/fpu_cluster.sv
dv/tb_clk_gen.sv
dv/fpu_cluster_tb.sv

// ==== logic/fp_format_pkg.sv ====
// Single-precision word layout shared by the lanes and the top level.
// An operand travels as a packed union so it can be read as raw bits
// or through its sign, exponent and mantissa fields.

package fp_format_pkg;

  localparam int FLEN  = 32;
  localparam int EXP_W = 8;
  localparam int MAN_W = 23;

  typedef struct packed {
    logic             sign;
    logic [EXP_W-1:0] exponent;
    logic [MAN_W-1:0] mantissa;
  } fp32_fields_t;

  // Same 32 bits, two views
  typedef union packed {
    logic [FLEN-1:0] raw;
    fp32_fields_t    f;
  } fp_word_u;

  // One-hot classify mask, RISC-V fclass bit order
  localparam int CLASS_W           = 10;
  localparam int CLASS_NEG_INF     = 0;
  localparam int CLASS_NEG_NORM    = 1;
  localparam int CLASS_NEG_SUBNORM = 2;
  localparam int CLASS_NEG_ZERO    = 3;
  localparam int CLASS_POS_ZERO    = 4;
  localparam int CLASS_POS_SUBNORM = 5;
  localparam int CLASS_POS_NORM    = 6;
  localparam int CLASS_POS_INF     = 7;
  localparam int CLASS_SNAN        = 8;
  localparam int CLASS_QNAN        = 9;

  // Quiet NaN with a zero payload
  localparam logic [FLEN-1:0] CANON_NAN = 32'h7fc0_0000;

endpackage

// ==== logic/fpu_cluster.sv ====
// Top level of the non-computational FP cluster.
// One valid/ready request port feeds NUM_LANES lanes round-robin;
// results return in request order on one valid/ready output port.

module fpu_cluster #(
  parameter int NUM_LANES = 4,
  parameter int TAG_WIDTH = 8
) (
  input  logic                            clk_i,
  input  logic                            rst_n_i,
  input  fp_format_pkg::fp_word_u         operand_a_i,
  input  fp_format_pkg::fp_word_u         operand_b_i,
  input  fpu_op_pkg::fpu_op_e             op_i,
  input  logic                            op_mod_i,
  input  fpu_op_pkg::rnd_mode_e           rnd_mode_i,
  input  logic [TAG_WIDTH-1:0]            tag_i,
  input  logic                            in_valid_i,
  output logic                            in_ready_o,
  output logic [fp_format_pkg::FLEN-1:0]  result_o,
  output logic [fpu_op_pkg::STATUS_W-1:0] status_o,
  output logic [TAG_WIDTH-1:0]            tag_o,
  output logic                            out_valid_o,
  input  logic                            out_ready_i
);
  import fpu_op_pkg::*;
  import fp_format_pkg::*;

  logic [NUM_LANES-1:0]                in_valid;
  logic [NUM_LANES-1:0]                in_ready;
  logic [NUM_LANES-1:0]                res_valid;
  logic [NUM_LANES-1:0]                res_ready;
  logic [NUM_LANES-1:0][FLEN-1:0]      res_data;
  logic [NUM_LANES-1:0][STATUS_W-1:0]  res_status;
  logic [NUM_LANES-1:0][TAG_WIDTH-1:0] res_tag;

  fpu_dispatch #(
    .NUM_LANES (NUM_LANES)
  ) u_dispatch (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .in_valid_i   (in_valid_i),
    .in_ready_o   (in_ready_o),
    .lane_valid_o (in_valid),
    .lane_ready_i (in_ready)
  );

  // Request fields go to every lane, only one sees valid
  for (genvar i = 0; i < NUM_LANES; i++) begin : gen_lane
    fpu_noncomp_lane #(
      .TAG_WIDTH (TAG_WIDTH)
    ) u_lane (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .valid_i     (in_valid[i]),
      .ready_o     (in_ready[i]),
      .operand_a_i (operand_a_i),
      .operand_b_i (operand_b_i),
      .op_i        (op_i),
      .op_mod_i    (op_mod_i),
      .rnd_mode_i  (rnd_mode_i),
      .tag_i       (tag_i),
      .valid_o     (res_valid[i]),
      .ready_i     (res_ready[i]),
      .result_o    (res_data[i]),
      .status_o    (res_status[i]),
      .tag_o       (res_tag[i])
    );
  end

  fpu_collect #(
    .NUM_LANES (NUM_LANES),
    .TAG_WIDTH (TAG_WIDTH)
  ) u_collect (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .lane_valid_i  (res_valid),
    .lane_ready_o  (res_ready),
    .lane_result_i (res_data),
    .lane_status_i (res_status),
    .lane_tag_i    (res_tag),
    .out_valid_o   (out_valid_o),
    .out_ready_i   (out_ready_i),
    .result_o      (result_o),
    .status_o      (status_o),
    .tag_o         (tag_o)
  );

endmodule

// ==== logic/fpu_collect.sv ====
// Result collector for the lane cluster.
// Drains lanes with a rotating pointer that follows the issue order,
// so results leave in request order on a single valid/ready port.

module fpu_collect #(
  parameter int NUM_LANES = 4,
  parameter int TAG_WIDTH = 8
) (
  input  logic                                            clk_i,
  input  logic                                            rst_n_i,
  input  logic [NUM_LANES-1:0]                            lane_valid_i,
  output logic [NUM_LANES-1:0]                            lane_ready_o,
  input  logic [NUM_LANES-1:0][fp_format_pkg::FLEN-1:0]   lane_result_i,
  input  logic [NUM_LANES-1:0][fpu_op_pkg::STATUS_W-1:0]  lane_status_i,
  input  logic [NUM_LANES-1:0][TAG_WIDTH-1:0]             lane_tag_i,
  output logic                                            out_valid_o,
  input  logic                                            out_ready_i,
  output logic [fp_format_pkg::FLEN-1:0]                  result_o,
  output logic [fpu_op_pkg::STATUS_W-1:0]                 status_o,
  output logic [TAG_WIDTH-1:0]                            tag_o
);

  localparam int PTR_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;
  localparam logic [PTR_W-1:0] LAST_LANE = PTR_W'(NUM_LANES - 1);

  logic [PTR_W-1:0] drain_ptr_q;

  assign out_valid_o = lane_valid_i[drain_ptr_q];
  assign result_o    = lane_result_i[drain_ptr_q];
  assign status_o    = lane_status_i[drain_ptr_q];
  assign tag_o       = lane_tag_i[drain_ptr_q];

  // Other lanes hold their results until their turn
  always_comb begin
    lane_ready_o              = '0;
    lane_ready_o[drain_ptr_q] = out_ready_i;
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      drain_ptr_q <= '0;
    end else if (out_valid_o && out_ready_i) begin
      drain_ptr_q <= (drain_ptr_q == LAST_LANE) ? '0 : drain_ptr_q + 1'b1;
    end
  end

endmodule

// ==== logic/fpu_dispatch.sv ====
// Request distributor for the lane cluster.
// Hands each accepted request to the lane under a rotating issue pointer.
// Request fields are broadcast at the top level; only valid and ready are steered here.

module fpu_dispatch #(
  parameter int NUM_LANES = 4
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 in_valid_i,
  output logic                 in_ready_o,
  output logic [NUM_LANES-1:0] lane_valid_o,
  input  logic [NUM_LANES-1:0] lane_ready_i
);

  localparam int PTR_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;
  localparam logic [PTR_W-1:0] LAST_LANE = PTR_W'(NUM_LANES - 1);

  logic [PTR_W-1:0] issue_ptr_q;
  logic             accept;

  // Upstream only sees the lane whose turn it is
  assign in_ready_o = lane_ready_i[issue_ptr_q];
  assign accept     = in_valid_i && in_ready_o;

  always_comb begin
    lane_valid_o              = '0;
    lane_valid_o[issue_ptr_q] = in_valid_i;
  end

  // Advance on every accepted request, wrap after the last lane
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      issue_ptr_q <= '0;
    end else if (accept) begin
      if (issue_ptr_q == LAST_LANE) begin
        issue_ptr_q <= '0;
      end else begin
        issue_ptr_q <= issue_ptr_q + 1'b1;
      end
    end
  end

endmodule

// ==== logic/fpu_noncomp_lane.sv ====
// Two-stage lane for the single-precision non-computational operations.
// Stage 1 captures operands and their classes, stage 2 computes and holds the result.
// Each stage advances when the stage after it is empty or being drained.

module fpu_noncomp_lane #(
  parameter int TAG_WIDTH = 8
) (
  input  logic                            clk_i,
  input  logic                            rst_n_i,
  input  logic                            valid_i,
  output logic                            ready_o,
  input  fp_format_pkg::fp_word_u         operand_a_i,
  input  fp_format_pkg::fp_word_u         operand_b_i,
  input  fpu_op_pkg::fpu_op_e             op_i,
  input  logic                            op_mod_i,
  input  fpu_op_pkg::rnd_mode_e           rnd_mode_i,
  input  logic [TAG_WIDTH-1:0]            tag_i,
  output logic                            valid_o,
  input  logic                            ready_i,
  output logic [fp_format_pkg::FLEN-1:0]  result_o,
  output logic [fpu_op_pkg::STATUS_W-1:0] status_o,
  output logic [TAG_WIDTH-1:0]            tag_o
);
  import fpu_op_pkg::*;
  import fp_format_pkg::*;

  // One-hot class of a single operand
  function automatic logic [CLASS_W-1:0] classify(fp_word_u w);
    logic                exp_zero;
    logic                exp_ones;
    logic                man_zero;
    logic [CLASS_W-1:0]  mask;
    exp_zero = (w.f.exponent == '0);
    exp_ones = &w.f.exponent;
    man_zero = (w.f.mantissa == '0);
    mask     = '0;
    if (exp_ones && !man_zero) begin
      // Quiet bit is the mantissa MSB
      mask[w.f.mantissa[MAN_W-1] ? CLASS_QNAN : CLASS_SNAN] = 1'b1;
    end else if (exp_ones) begin
      mask[w.f.sign ? CLASS_NEG_INF : CLASS_POS_INF] = 1'b1;
    end else if (exp_zero && man_zero) begin
      mask[w.f.sign ? CLASS_NEG_ZERO : CLASS_POS_ZERO] = 1'b1;
    end else if (exp_zero) begin
      mask[w.f.sign ? CLASS_NEG_SUBNORM : CLASS_POS_SUBNORM] = 1'b1;
    end else begin
      mask[w.f.sign ? CLASS_NEG_NORM : CLASS_POS_NORM] = 1'b1;
    end
    return mask;
  endfunction

  logic                 s1_valid_q, s2_valid_q;
  logic                 s1_ready, s2_ready;
  fp_word_u             a_q, b_q;
  logic [CLASS_W-1:0]   cls_a_q, cls_b_q;
  fpu_op_e              op_q;
  logic                 op_mod_q;
  rnd_mode_e            rnd_q;
  logic [TAG_WIDTH-1:0] tag1_q;

  logic                 a_nan, b_nan, a_snan, b_snan, any_nan, both_zero;
  logic                 a_lt_b, cmp_lt, cmp_eq, cmp_bit, inj_sign, is_max;
  logic [FLEN-1:0]      res_d;
  logic [STATUS_W-1:0]  status_d;

  assign s2_ready = !s2_valid_q || ready_i;
  assign s1_ready = !s1_valid_q || s2_ready;
  assign ready_o  = s1_ready;
  assign valid_o  = s2_valid_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      s1_valid_q <= 1'b0;
      s2_valid_q <= 1'b0;
    end else begin
      if (s1_ready) s1_valid_q <= valid_i;
      if (s2_ready) s2_valid_q <= s1_valid_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i && s1_ready) begin
      a_q      <= operand_a_i;
      b_q      <= operand_b_i;
      cls_a_q  <= classify(operand_a_i);
      cls_b_q  <= classify(operand_b_i);
      op_q     <= op_i;
      op_mod_q <= op_mod_i;
      rnd_q    <= rnd_mode_i;
      tag1_q   <= tag_i;
    end
  end

  assign a_snan    = cls_a_q[CLASS_SNAN];
  assign b_snan    = cls_b_q[CLASS_SNAN];
  assign a_nan     = a_snan | cls_a_q[CLASS_QNAN];
  assign b_nan     = b_snan | cls_b_q[CLASS_QNAN];
  assign any_nan   = a_nan | b_nan;
  assign both_zero = (cls_a_q[CLASS_NEG_ZERO] | cls_a_q[CLASS_POS_ZERO]) &
                     (cls_b_q[CLASS_NEG_ZERO] | cls_b_q[CLASS_POS_ZERO]);

  // Total order on non-NaN values, -0 below +0
  assign a_lt_b = (a_q.f.sign != b_q.f.sign) ? a_q.f.sign :
                  a_q.f.sign ? (b_q.raw[FLEN-2:0] < a_q.raw[FLEN-2:0]) :
                               (a_q.raw[FLEN-2:0] < b_q.raw[FLEN-2:0]);

  // IEEE compare treats the two zeros as equal
  assign cmp_eq = (a_q.raw == b_q.raw) | both_zero;
  assign cmp_lt = a_lt_b & ~both_zero;
  assign is_max = (rnd_q == RTZ);

  always_comb begin
    cmp_bit  = 1'b0;
    inj_sign = b_q.f.sign;
    case (rnd_q)
      RNE: cmp_bit = cmp_lt | cmp_eq;
      RTZ: begin
        cmp_bit  = cmp_lt;
        inj_sign = ~b_q.f.sign;
      end
      RDN: begin
        cmp_bit  = cmp_eq;
        inj_sign = a_q.f.sign ^ b_q.f.sign;
      end
      default: ;
    endcase
  end

  always_comb begin
    res_d    = a_q.raw;
    status_d = '0;
    unique case (op_q)
      OP_MINMAX: begin
        status_d[FLAG_NV] = a_snan | b_snan;
        if (a_nan && b_nan)       res_d = CANON_NAN;
        else if (a_nan)           res_d = b_q.raw;
        else if (b_nan)           res_d = a_q.raw;
        else if (is_max ^ a_lt_b) res_d = a_q.raw;
        else                      res_d = b_q.raw;
      end
      OP_SGNJ: res_d = {inj_sign, a_q.raw[FLEN-2:0]};
      OP_CMP: begin
        // Signaling compares flag any NaN, eq only flags sNaN
        status_d[FLAG_NV] = a_snan | b_snan | (any_nan & (rnd_q inside {RNE, RTZ}));
        res_d = FLEN'((cmp_bit & ~any_nan) ^ op_mod_q);
      end
      OP_CLASS: res_d = FLEN'(cls_a_q);
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (s1_valid_q && s2_ready) begin
      result_o <= res_d;
      status_o <= status_d;
      tag_o    <= tag1_q;
    end
  end

endmodule

// ==== logic/fpu_op_pkg.sv ====
// Operation encodings for the non-computational FP cluster.
// The sub-operation selector reuses the RISC-V funct3 rounding-mode field.
// Status flags follow the fflags layout, NV in the top bit.

package fpu_op_pkg;

  // Operation groups routed to the lanes
  typedef enum logic [1:0] {
    OP_MINMAX = 2'd0,
    OP_SGNJ   = 2'd1,
    OP_CMP    = 2'd2,
    OP_CLASS  = 2'd3
  } fpu_op_e;

  // funct3 meaning per operation
  //   OP_MINMAX : RNE min, RTZ max
  //   OP_SGNJ   : RNE inject, RTZ inject negated, RDN inject xor
  //   OP_CMP    : RNE le, RTZ lt, RDN eq
  typedef enum logic [2:0] {
    RNE = 3'b000,
    RTZ = 3'b001,
    RDN = 3'b010
  } rnd_mode_e;

  localparam int STATUS_W = 5;

  // Bit positions within status
  localparam int FLAG_NV = 4;
  localparam int FLAG_DZ = 3;
  localparam int FLAG_OF = 2;
  localparam int FLAG_UF = 1;
  localparam int FLAG_NX = 0;

endpackage
